//--- verilog/dbg_cfg_pkg.sv
// --------------------
// debug platform configuration
// hart count, hold-off window and the
// register map of the small debug module
// --------------------

package dbg_cfg_pkg;

  // harts that can be halted
  localparam int unsigned NumHarts = 2;

  // cycles after reset before debug requests may reach the harts
  localparam int unsigned HoldoffCycles = 50;
  localparam int unsigned HoldoffWidth = $clog2(HoldoffCycles + 1);

  typedef logic [NumHarts-1:0]     hart_mask_t;
  typedef logic [HoldoffWidth-1:0] holdoff_cnt_t;

  // register map, 7 bit DMI addresses
  localparam logic [6:0] AddrData0     = 7'h04;
  localparam logic [6:0] AddrDmcontrol = 7'h10;
  localparam logic [6:0] AddrDmstatus  = 7'h11;

  // control register fields
  localparam int unsigned CtrlActiveBit   = 0;
  localparam int unsigned CtrlNdmresetBit = 1;
  // hart n uses bit CtrlHaltreqLsb + n
  localparam int unsigned CtrlHaltreqLsb  = 2;

endpackage

//--- verilog/dmi_pkg.sv
// --------------------
// debug module interface protocol types
// request and response codes plus the
// states of the request machine
// --------------------

package dmi_pkg;

  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] dmi_data_t;

  // request operation
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2,
    DMI_RSVD  = 2'd3
  } dmi_op_e;

  // response code
  typedef enum logic [1:0] {
    RESP_OK     = 2'd0,
    RESP_FAILED = 2'd2
  } dmi_resp_e;

  // request machine
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP
  } req_state_e;

endpackage

//--- verilog/dmi_source_mux.sv
// --------------------
// DMI source mux
// selects JTAG or DTM as the active transport,
// switching only between transactions
// --------------------

`timescale 1ns/1ps

module dmi_source_mux (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                mode_i,
  input  logic                fsm_idle_i,
  // jtag side source
  input  logic                jtag_req_valid_i,
  output logic                jtag_req_ready_o,
  input  dmi_pkg::dmi_addr_t  jtag_req_addr_i,
  input  dmi_pkg::dmi_op_e    jtag_req_op_i,
  input  dmi_pkg::dmi_data_t  jtag_req_data_i,
  output logic                jtag_resp_valid_o,
  input  logic                jtag_resp_ready_i,
  output dmi_pkg::dmi_data_t  jtag_resp_data_o,
  output dmi_pkg::dmi_resp_e  jtag_resp_code_o,
  // simulation dtm source
  input  logic                dtm_req_valid_i,
  output logic                dtm_req_ready_o,
  input  dmi_pkg::dmi_addr_t  dtm_req_addr_i,
  input  dmi_pkg::dmi_op_e    dtm_req_op_i,
  input  dmi_pkg::dmi_data_t  dtm_req_data_i,
  output logic                dtm_resp_valid_o,
  input  logic                dtm_resp_ready_i,
  output dmi_pkg::dmi_data_t  dtm_resp_data_o,
  output dmi_pkg::dmi_resp_e  dtm_resp_code_o,
  // toward the request machine
  output logic                req_valid_o,
  input  logic                req_ready_i,
  output dmi_pkg::dmi_addr_t  req_addr_o,
  output dmi_pkg::dmi_op_e    req_op_o,
  output dmi_pkg::dmi_data_t  req_data_o,
  input  logic                resp_valid_i,
  output logic                resp_ready_o,
  input  dmi_pkg::dmi_data_t  resp_data_i,
  input  dmi_pkg::dmi_resp_e  resp_code_i
);

  logic sel_jtag_q;
  logic req_fire;

  assign req_fire = req_valid_o && req_ready_i;

  // latch the choice only while nothing is in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_sel
    if (!rst_ni) begin
      sel_jtag_q <= 1'b0;
    end else if (fsm_idle_i && !req_fire) begin
      sel_jtag_q <= mode_i;
    end
  end

  // --------------------
  // request path
  // --------------------
  assign req_valid_o = sel_jtag_q ? jtag_req_valid_i : dtm_req_valid_i;
  assign req_addr_o  = sel_jtag_q ? jtag_req_addr_i  : dtm_req_addr_i;
  assign req_op_o    = sel_jtag_q ? jtag_req_op_i    : dtm_req_op_i;
  assign req_data_o  = sel_jtag_q ? jtag_req_data_i  : dtm_req_data_i;

  assign jtag_req_ready_o = sel_jtag_q && req_ready_i;
  assign dtm_req_ready_o  = !sel_jtag_q && req_ready_i;

  // --------------------
  // response path
  // --------------------
  assign resp_ready_o = sel_jtag_q ? jtag_resp_ready_i : dtm_resp_ready_i;

  // unselected source never sees a response
  assign jtag_resp_valid_o = sel_jtag_q && resp_valid_i;
  assign dtm_resp_valid_o  = !sel_jtag_q && resp_valid_i;
  assign jtag_resp_data_o  = resp_data_i;
  assign jtag_resp_code_o  = resp_code_i;
  assign dtm_resp_data_o   = resp_data_i;
  assign dtm_resp_code_o   = resp_code_i;

  // a transaction must finish on the source that started it
  a_sel_stable_busy : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !fsm_idle_i |=> $stable(sel_jtag_q)
  ) else $error("source select changed during a transaction");

endmodule

//--- verilog/dmi_req_fsm.sv
// --------------------
// DMI request machine
// takes one request at a time, performs it on
// the register block and holds the response
// until the source takes it
// --------------------

`timescale 1ns/1ps

module dmi_req_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  // request channel
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  dmi_pkg::dmi_addr_t  req_addr_i,
  input  dmi_pkg::dmi_op_e    req_op_i,
  input  dmi_pkg::dmi_data_t  req_data_i,
  // response channel
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output dmi_pkg::dmi_data_t  resp_data_o,
  output dmi_pkg::dmi_resp_e  resp_code_o,
  output logic                idle_o,
  // register port
  output logic                reg_en_o,
  output logic                reg_we_o,
  output dmi_pkg::dmi_addr_t  reg_addr_o,
  output dmi_pkg::dmi_data_t  reg_wdata_o,
  input  dmi_pkg::dmi_data_t  reg_rdata_i,
  input  logic                reg_err_i
);

  dmi_pkg::req_state_e state_d, state_q;
  dmi_pkg::dmi_addr_t  addr_q;
  dmi_pkg::dmi_op_e    op_q;
  dmi_pkg::dmi_data_t  wdata_q;
  dmi_pkg::dmi_data_t  resp_data_d, resp_data_q;
  dmi_pkg::dmi_resp_e  resp_code_d, resp_code_q;
  logic                req_fire;
  logic                resp_fire;
  logic                in_access;

  assign req_ready_o  = (state_q == dmi_pkg::IDLE);
  assign idle_o       = (state_q == dmi_pkg::IDLE);
  assign resp_valid_o = (state_q == dmi_pkg::RESP);
  assign in_access    = (state_q == dmi_pkg::ACCESS);
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_fire    = resp_valid_o && resp_ready_i;

  // --------------------
  // register access
  // --------------------
  // nop and reserved ops never touch the registers
  assign reg_en_o    = in_access && (op_q inside {dmi_pkg::DMI_READ, dmi_pkg::DMI_WRITE});
  assign reg_we_o    = in_access && (op_q == dmi_pkg::DMI_WRITE);
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;

  always_comb begin : p_resp
    resp_data_d = '0;
    resp_code_d = dmi_pkg::RESP_OK;
    case (op_q)
      dmi_pkg::DMI_READ: begin
        if (reg_err_i) begin
          resp_code_d = dmi_pkg::RESP_FAILED;
        end else begin
          resp_data_d = reg_rdata_i;
        end
      end
      dmi_pkg::DMI_WRITE: begin
        if (reg_err_i) begin
          resp_code_d = dmi_pkg::RESP_FAILED;
        end
      end
      dmi_pkg::DMI_RSVD: resp_code_d = dmi_pkg::RESP_FAILED;
      default: ;
    endcase
  end

  // --------------------
  // state sequencing
  // --------------------
  always_comb begin : p_next
    state_d = state_q;
    case (state_q)
      dmi_pkg::IDLE:   if (req_fire) state_d = dmi_pkg::ACCESS;
      dmi_pkg::ACCESS: state_d = dmi_pkg::RESP;
      dmi_pkg::RESP:   if (resp_fire) state_d = dmi_pkg::IDLE;
      default:         state_d = dmi_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= dmi_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin : p_payload
    if (req_fire) begin
      addr_q  <= req_addr_i;
      op_q    <= req_op_i;
      wdata_q <= req_data_i;
    end
    if (in_access) begin
      resp_data_q <= resp_data_d;
      resp_code_q <= resp_code_d;
    end
  end

  assign resp_data_o = resp_data_q;
  assign resp_code_o = resp_code_q;

  // stalled response keeps valid and payload
  a_resp_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=>
      resp_valid_o && $stable(resp_data_o) && $stable(resp_code_o)
  ) else $error("response changed under back-pressure");

endmodule

//--- verilog/dm_regs.sv
// --------------------
// debug module registers
// control, status and scratch data, plus the
// per-hart debug requests gated by hold-off
// --------------------

`timescale 1ns/1ps

module dm_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     en_i,
  input  logic                     we_i,
  input  dmi_pkg::dmi_addr_t       addr_i,
  input  dmi_pkg::dmi_data_t       wdata_i,
  output dmi_pkg::dmi_data_t       rdata_o,
  output logic                     err_o,
  input  logic                     holdoff_done_i,
  output dbg_cfg_pkg::hart_mask_t  debug_req_o,
  output logic                     ndmreset_o
);

  dmi_pkg::dmi_data_t       data0_q;
  logic                     active_q;
  logic                     ndmreset_q;
  dbg_cfg_pkg::hart_mask_t  haltreq_q;
  dmi_pkg::dmi_data_t       ctrl_rdata;
  dmi_pkg::dmi_data_t       status_rdata;
  logic                     wr_data0;
  logic                     wr_ctrl;

  assign wr_data0 = en_i && we_i && (addr_i == dbg_cfg_pkg::AddrData0);
  assign wr_ctrl  = en_i && we_i && (addr_i == dbg_cfg_pkg::AddrDmcontrol);

  // --------------------
  // register storage
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      data0_q    <= '0;
      active_q   <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= '0;
    end else begin
      if (wr_data0) begin
        data0_q <= wdata_i;
      end
      if (wr_ctrl) begin
        active_q   <= wdata_i[dbg_cfg_pkg::CtrlActiveBit];
        ndmreset_q <= wdata_i[dbg_cfg_pkg::CtrlNdmresetBit];
        haltreq_q  <= wdata_i[dbg_cfg_pkg::CtrlHaltreqLsb +: dbg_cfg_pkg::NumHarts];
      end
    end
  end

  // control readback, upper bits stay zero
  always_comb begin : p_ctrl_rdata
    ctrl_rdata = '0;
    ctrl_rdata[dbg_cfg_pkg::CtrlActiveBit]   = active_q;
    ctrl_rdata[dbg_cfg_pkg::CtrlNdmresetBit] = ndmreset_q;
    ctrl_rdata[dbg_cfg_pkg::CtrlHaltreqLsb +: dbg_cfg_pkg::NumHarts] = haltreq_q;
  end

  // status bit 0 shows the end of hold-off
  assign status_rdata = dmi_pkg::dmi_data_t'(holdoff_done_i);

  // --------------------
  // read decode
  // --------------------
  always_comb begin : p_read
    rdata_o = '0;
    err_o   = 1'b0;
    case (addr_i)
      dbg_cfg_pkg::AddrData0:     rdata_o = data0_q;
      dbg_cfg_pkg::AddrDmcontrol: rdata_o = ctrl_rdata;
      dbg_cfg_pkg::AddrDmstatus: begin
        rdata_o = status_rdata;
        // read-only
        err_o   = we_i;
      end
      default:                    err_o   = 1'b1;
    endcase
  end

  // halt requests only once active and past hold-off
  assign debug_req_o = haltreq_q & {dbg_cfg_pkg::NumHarts{active_q && holdoff_done_i}};
  assign ndmreset_o  = ndmreset_q;

endmodule

//--- verilog/debug_holdoff_timer.sv
// --------------------
// debug hold-off timer
// counts down after reset so that boot code
// runs before the first halt request
// --------------------

`timescale 1ns/1ps

module debug_holdoff_timer (
  input  logic clk_i,
  input  logic rst_ni,
  output logic done_o
);

  dbg_cfg_pkg::holdoff_cnt_t cnt_d, cnt_q;

  // saturate at zero
  assign cnt_d  = (cnt_q != '0) ? cnt_q - 1'b1 : cnt_q;
  assign done_o = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= dbg_cfg_pkg::holdoff_cnt_t'(dbg_cfg_pkg::HoldoffCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // once released the window only shrinks
  a_cnt_no_rise : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= $past(cnt_q)
  ) else $error("hold-off count rose outside reset");

endmodule

//--- verilog/debug_front_top.sv
// --------------------
// debug front end
// two DMI transports sharing one debug module
// with a hold-off on the halt requests
// --------------------

`timescale 1ns/1ps

module debug_front_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     mode_i,
  // jtag side source
  input  logic                     jtag_req_valid_i,
  output logic                     jtag_req_ready_o,
  input  dmi_pkg::dmi_addr_t       jtag_req_addr_i,
  input  dmi_pkg::dmi_op_e         jtag_req_op_i,
  input  dmi_pkg::dmi_data_t       jtag_req_data_i,
  output logic                     jtag_resp_valid_o,
  input  logic                     jtag_resp_ready_i,
  output dmi_pkg::dmi_data_t       jtag_resp_data_o,
  output dmi_pkg::dmi_resp_e       jtag_resp_code_o,
  // simulation dtm source
  input  logic                     dtm_req_valid_i,
  output logic                     dtm_req_ready_o,
  input  dmi_pkg::dmi_addr_t       dtm_req_addr_i,
  input  dmi_pkg::dmi_op_e         dtm_req_op_i,
  input  dmi_pkg::dmi_data_t       dtm_req_data_i,
  output logic                     dtm_resp_valid_o,
  input  logic                     dtm_resp_ready_i,
  output dmi_pkg::dmi_data_t       dtm_resp_data_o,
  output dmi_pkg::dmi_resp_e       dtm_resp_code_o,
  // to the harts
  output dbg_cfg_pkg::hart_mask_t  debug_req_o,
  output logic                     ndmreset_o
);

  // shared dmi between mux and request machine
  logic                dmi_req_valid;
  logic                dmi_req_ready;
  dmi_pkg::dmi_addr_t  dmi_req_addr;
  dmi_pkg::dmi_op_e    dmi_req_op;
  dmi_pkg::dmi_data_t  dmi_req_data;
  logic                dmi_resp_valid;
  logic                dmi_resp_ready;
  dmi_pkg::dmi_data_t  dmi_resp_data;
  dmi_pkg::dmi_resp_e  dmi_resp_code;
  logic                fsm_idle;

  // register port
  logic                reg_en;
  logic                reg_we;
  dmi_pkg::dmi_addr_t  reg_addr;
  dmi_pkg::dmi_data_t  reg_wdata;
  dmi_pkg::dmi_data_t  reg_rdata;
  logic                reg_err;
  logic                holdoff_done;

  dmi_source_mux i_dmi_source_mux (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .mode_i            ( mode_i            ),
    .fsm_idle_i        ( fsm_idle          ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_req_addr_i   ( jtag_req_addr_i   ),
    .jtag_req_op_i     ( jtag_req_op_i     ),
    .jtag_req_data_i   ( jtag_req_data_i   ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_resp_data_o  ( jtag_resp_data_o  ),
    .jtag_resp_code_o  ( jtag_resp_code_o  ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_req_addr_i    ( dtm_req_addr_i    ),
    .dtm_req_op_i      ( dtm_req_op_i      ),
    .dtm_req_data_i    ( dtm_req_data_i    ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_resp_data_o   ( dtm_resp_data_o   ),
    .dtm_resp_code_o   ( dtm_resp_code_o   ),
    .req_valid_o       ( dmi_req_valid     ),
    .req_ready_i       ( dmi_req_ready     ),
    .req_addr_o        ( dmi_req_addr      ),
    .req_op_o          ( dmi_req_op        ),
    .req_data_o        ( dmi_req_data      ),
    .resp_valid_i      ( dmi_resp_valid    ),
    .resp_ready_o      ( dmi_resp_ready    ),
    .resp_data_i       ( dmi_resp_data     ),
    .resp_code_i       ( dmi_resp_code     )
  );

  dmi_req_fsm i_dmi_req_fsm (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .req_valid_i  ( dmi_req_valid  ),
    .req_ready_o  ( dmi_req_ready  ),
    .req_addr_i   ( dmi_req_addr   ),
    .req_op_i     ( dmi_req_op     ),
    .req_data_i   ( dmi_req_data   ),
    .resp_valid_o ( dmi_resp_valid ),
    .resp_ready_i ( dmi_resp_ready ),
    .resp_data_o  ( dmi_resp_data  ),
    .resp_code_o  ( dmi_resp_code  ),
    .idle_o       ( fsm_idle       ),
    .reg_en_o     ( reg_en         ),
    .reg_we_o     ( reg_we         ),
    .reg_addr_o   ( reg_addr       ),
    .reg_wdata_o  ( reg_wdata      ),
    .reg_rdata_i  ( reg_rdata      ),
    .reg_err_i    ( reg_err        )
  );

  dm_regs i_dm_regs (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .en_i           ( reg_en       ),
    .we_i           ( reg_we       ),
    .addr_i         ( reg_addr     ),
    .wdata_i        ( reg_wdata    ),
    .rdata_o        ( reg_rdata    ),
    .err_o          ( reg_err      ),
    .holdoff_done_i ( holdoff_done ),
    .debug_req_o    ( debug_req_o  ),
    .ndmreset_o     ( ndmreset_o   )
  );

  debug_holdoff_timer i_debug_holdoff_timer (
    .clk_i  ( clk_i        ),
    .rst_ni ( rst_ni       ),
    .done_o ( holdoff_done )
  );

endmodule

//--- verif/tb_clk_gen.sv
// --------------------
// testbench clock source
// free running clock with a 20 ns period
// --------------------

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  localparam int HalfPeriod = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

endmodule

//--- verif/debug_front_tb.sv
// --------------------
// debug front end testbench
// table of DMI transactions over both sources,
// plus hold-off, isolation and output checks
// --------------------

`timescale 1ns/1ps

module debug_front_tb;

  localparam int ResetCycles   = 16;
  localparam int DriveDelay    = 2;
  localparam int TimeoutCycles = 100;
  // earliest edge after acceptance that can take the response
  localparam int RespLatency   = 2;
  localparam int MaxRows       = 32;

  typedef struct packed {
    int                  test;
    logic                src;
    dmi_pkg::dmi_op_e    op;
    dmi_pkg::dmi_addr_t  addr;
    dmi_pkg::dmi_data_t  wdata;
    logic                rnd;
    dmi_pkg::dmi_resp_e  exp_code;
    dmi_pkg::dmi_data_t  exp_data;
    logic                exp_last;
    int                  stall;
  } row_t;

  logic clk;
  logic rst_n;
  logic mode;
  logic jtag_req_valid, jtag_req_ready, jtag_resp_valid, jtag_resp_ready;
  logic dtm_req_valid, dtm_req_ready, dtm_resp_valid, dtm_resp_ready;
  dmi_pkg::dmi_addr_t       jtag_req_addr, dtm_req_addr;
  dmi_pkg::dmi_op_e         jtag_req_op, dtm_req_op;
  dmi_pkg::dmi_data_t       jtag_req_data, dtm_req_data, jtag_resp_data, dtm_resp_data;
  dmi_pkg::dmi_resp_e       jtag_resp_code, dtm_resp_code;
  dbg_cfg_pkg::hart_mask_t  debug_req;
  logic                     ndmreset;

  row_t                     rows [MaxRows];
  int                       n_rows, n_tests, n_txns, n_errors, err_mark;
  logic [31:0]              lcg_state;
  dmi_pkg::dmi_data_t       last_data0;
  dbg_cfg_pkg::hart_mask_t  dbg_at_access;
  logic                     iso_check;

  tb_clk_gen i_clk_gen (.clk_o(clk));

  debug_front_top dut0 (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .mode_i            ( mode            ),
    .jtag_req_valid_i  ( jtag_req_valid  ),
    .jtag_req_ready_o  ( jtag_req_ready  ),
    .jtag_req_addr_i   ( jtag_req_addr   ),
    .jtag_req_op_i     ( jtag_req_op     ),
    .jtag_req_data_i   ( jtag_req_data   ),
    .jtag_resp_valid_o ( jtag_resp_valid ),
    .jtag_resp_ready_i ( jtag_resp_ready ),
    .jtag_resp_data_o  ( jtag_resp_data  ),
    .jtag_resp_code_o  ( jtag_resp_code  ),
    .dtm_req_valid_i   ( dtm_req_valid   ),
    .dtm_req_ready_o   ( dtm_req_ready   ),
    .dtm_req_addr_i    ( dtm_req_addr    ),
    .dtm_req_op_i      ( dtm_req_op      ),
    .dtm_req_data_i    ( dtm_req_data    ),
    .dtm_resp_valid_o  ( dtm_resp_valid  ),
    .dtm_resp_ready_i  ( dtm_resp_ready  ),
    .dtm_resp_data_o   ( dtm_resp_data   ),
    .dtm_resp_code_o   ( dtm_resp_code   ),
    .debug_req_o       ( debug_req       ),
    .ndmreset_o        ( ndmreset        )
  );

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // control word from the documented field map
  function automatic dmi_pkg::dmi_data_t ctrl_word(input logic active, input logic ndm,
                                                   input dbg_cfg_pkg::hart_mask_t mask);
    dmi_pkg::dmi_data_t w;
    w = '0;
    w[dbg_cfg_pkg::CtrlActiveBit]   = active;
    w[dbg_cfg_pkg::CtrlNdmresetBit] = ndm;
    w[dbg_cfg_pkg::CtrlHaltreqLsb +: dbg_cfg_pkg::NumHarts] = mask;
    return w;
  endfunction

  function automatic logic req_ready_of(input logic src);
    return src ? jtag_req_ready : dtm_req_ready;
  endfunction

  function automatic logic resp_valid_of(input logic src);
    return src ? jtag_resp_valid : dtm_resp_valid;
  endfunction

  function automatic dmi_pkg::dmi_data_t resp_data_of(input logic src);
    return src ? jtag_resp_data : dtm_resp_data;
  endfunction

  function automatic dmi_pkg::dmi_resp_e resp_code_of(input logic src);
    return src ? jtag_resp_code : dtm_resp_code;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      2:       return "2 data register round trip";
      3:       return "3 error responses";
      default: return "5 response back-pressure";
    endcase
  endfunction

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_errors++;
    $display("Fail at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic abort_run(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic begin_test();
    err_mark = n_errors;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (n_errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_errors - err_mark);
    end
  endtask

  task automatic add_row(input int test, input logic src, input dmi_pkg::dmi_op_e op,
                         input dmi_pkg::dmi_addr_t addr, input dmi_pkg::dmi_data_t wdata,
                         input logic rnd, input dmi_pkg::dmi_resp_e exp_code,
                         input logic exp_last, input int stall);
    rows[n_rows] = '{test, src, op, addr, wdata, rnd, exp_code, 32'h0, exp_last, stall};
    n_rows++;
  endtask

  task automatic drive_req(input logic src, input logic valid, input dmi_pkg::dmi_op_e op,
                           input dmi_pkg::dmi_addr_t addr, input dmi_pkg::dmi_data_t data);
    if (src) begin
      jtag_req_valid = valid;
      jtag_req_op    = op;
      jtag_req_addr  = addr;
      jtag_req_data  = data;
    end else begin
      dtm_req_valid  = valid;
      dtm_req_op     = op;
      dtm_req_addr   = addr;
      dtm_req_data   = data;
    end
  endtask

  task automatic drive_resp_ready(input logic src, input logic ready);
    if (src) begin
      jtag_resp_ready = ready;
    end else begin
      dtm_resp_ready  = ready;
    end
  endtask

  // a parked DTM request must stay invisible
  task automatic check_isolation();
    if (iso_check && dtm_req_ready !== 1'b0) fail_value("dtm_req_ready", dtm_req_ready, 0);
    if (iso_check && dtm_resp_valid !== 1'b0) fail_value("dtm_resp_valid", dtm_resp_valid, 0);
  endtask

  task automatic check_in_flight(input logic src);
    if (req_ready_of(src) !== 1'b0) fail_value("req_ready in flight", req_ready_of(src), 0);
    check_isolation();
  endtask

  // mode is latched on the next edge while idle
  task automatic select_source(input logic src);
    @(posedge clk);
    #(DriveDelay);
    mode = src;
    @(posedge clk);
    #(DriveDelay);
  endtask

  // --------------------
  // one DMI transaction
  // --------------------
  task automatic run_txn(input logic src, input dmi_pkg::dmi_op_e op,
                         input dmi_pkg::dmi_addr_t addr, input dmi_pkg::dmi_data_t wdata,
                         input int stall, output dmi_pkg::dmi_data_t rdata,
                         output dmi_pkg::dmi_resp_e code);
    int waited;
    int edges;
    n_txns++;
    @(posedge clk);
    #(DriveDelay);
    drive_req(src, 1'b1, op, addr, wdata);
    waited = 0;
    while (req_ready_of(src) !== 1'b1) begin
      if (waited == TimeoutCycles) abort_run("request was never accepted");
      check_isolation();
      @(posedge clk);
      #(DriveDelay);
      waited++;
    end
    // ready seen, so the next edge accepts
    @(posedge clk);
    #(DriveDelay);
    drive_req(src, 1'b0, dmi_pkg::DMI_NOP, '0, '0);
    dbg_at_access = debug_req;
    edges = 1;
    while (resp_valid_of(src) !== 1'b1) begin
      if (edges == TimeoutCycles) abort_run("response never became valid");
      check_in_flight(src);
      @(posedge clk);
      #(DriveDelay);
      edges++;
    end
    if (edges != RespLatency) fail_value("resp_valid latency", edges, RespLatency);
    rdata = resp_data_of(src);
    code  = resp_code_of(src);
    for (int i = 0; i < stall; i++) begin
      check_in_flight(src);
      @(posedge clk);
      #(DriveDelay);
      if (resp_valid_of(src) !== 1'b1) fail_value("resp_valid under stall", 0, 1);
      if (resp_data_of(src) !== rdata) fail_value("resp_data under stall",
                                                  resp_data_of(src), rdata);
      if (resp_code_of(src) !== code) fail_value("resp_code under stall",
                                                 resp_code_of(src), code);
    end
    check_in_flight(src);
    drive_resp_ready(src, 1'b1);
    @(posedge clk);
    #(DriveDelay);
    drive_resp_ready(src, 1'b0);
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial begin
    row_t                row;
    dmi_pkg::dmi_data_t  wdata, exp_data, rdata;
    dmi_pkg::dmi_resp_e  code;
    int                  stall, cur_test, reads;
    logic                cur_src, seen_done;

    rst_n = 1'b0;
    mode  = 1'b0;
    drive_req(1'b1, 1'b0, dmi_pkg::DMI_NOP, '0, '0);
    drive_req(1'b0, 1'b0, dmi_pkg::DMI_NOP, '0, '0);
    drive_resp_ready(1'b1, 1'b0);
    drive_resp_ready(1'b0, 1'b0);
    lcg_state  = 32'd71;
    last_data0 = '0;
    iso_check  = 1'b0;
    n_rows = 0;
    n_tests = 0;
    n_txns = 0;
    n_errors = 0;
    cur_src = 1'b0;

    add_row(2, 0, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, 0);
    add_row(2, 0, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, 0);
    add_row(2, 0, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, 1);
    add_row(2, 0, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, 1);
    add_row(2, 1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, 0);
    add_row(2, 1, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, 0);
    add_row(2, 1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, 1);
    add_row(2, 1, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, 1);
    add_row(3, 1, dmi_pkg::DMI_READ,  7'h3f, '0, 0, dmi_pkg::RESP_FAILED, 0, 0);
    add_row(3, 1, dmi_pkg::DMI_RSVD,  dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_FAILED, 0, 0);
    add_row(3, 1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrDmstatus, '1, 0,
            dmi_pkg::RESP_FAILED, 0, 0);
    add_row(3, 0, dmi_pkg::DMI_NOP,   dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, 0);
    // rsvd and nop left the data register alone
    add_row(3, 0, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, 0);
    add_row(5, 0, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, -1);
    add_row(5, 0, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, -1);
    add_row(5, 1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, '0, 1, dmi_pkg::RESP_OK, 0, -1);
    add_row(5, 1, dmi_pkg::DMI_READ,  dbg_cfg_pkg::AddrData0, '0, 0, dmi_pkg::RESP_OK, 1, -1);

    repeat (ResetCycles) @(posedge clk);
    #(DriveDelay);
    rst_n = 1'b1;

    // hold-off gating, with the reset state first
    begin_test();
    if (dtm_req_ready !== 1'b1) fail_value("dtm_req_ready after reset", dtm_req_ready, 1);
    if (jtag_req_ready !== 1'b0) fail_value("jtag_req_ready after reset", jtag_req_ready, 0);
    if (dtm_resp_valid !== 1'b0) fail_value("dtm_resp_valid after reset", dtm_resp_valid, 0);
    if (jtag_resp_valid !== 1'b0) fail_value("jtag_resp_valid after reset", jtag_resp_valid, 0);
    if (debug_req !== '0) fail_value("debug_req_o after reset", debug_req, 0);
    if (ndmreset !== 1'b0) fail_value("ndmreset_o after reset", ndmreset, 0);
    run_txn(0, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrDmcontrol, ctrl_word(1, 0, 2'b01), 0,
            rdata, code);
    if (code !== dmi_pkg::RESP_OK) fail_value("resp_code", code, dmi_pkg::RESP_OK);
    seen_done = 1'b0;
    reads = 0;
    while (!seen_done) begin
      if (reads == 40) abort_run("hold-off window never ended");
      run_txn(0, dmi_pkg::DMI_READ, dbg_cfg_pkg::AddrDmstatus, '0, 0, rdata, code);
      if (code !== dmi_pkg::RESP_OK) fail_value("resp_code", code, dmi_pkg::RESP_OK);
      if (rdata[0] && reads == 0) fail_value("dmstatus[0] on first read", rdata[0], 0);
      if (rdata[0]) begin
        seen_done = 1'b1;
        if (dbg_at_access !== 2'b01) fail_value("debug_req_o after hold-off", dbg_at_access, 1);
      end else if (dbg_at_access !== '0) begin
        fail_value("debug_req_o during hold-off", dbg_at_access, 0);
      end
      reads++;
    end
    end_test("1 hold-off gating");

    // table rows for tests 2, 3 and 5
    cur_test = rows[0].test;
    begin_test();
    for (int r = 0; r < n_rows; r++) begin
      row = rows[r];
      if (row.test != cur_test) begin
        end_test(test_name(cur_test));
        cur_test = row.test;
        begin_test();
      end
      if (row.src != cur_src) begin
        select_source(row.src);
        cur_src = row.src;
      end
      wdata    = row.rnd ? lcg_next() : row.wdata;
      stall    = (row.stall < 0) ? 1 + int'(lcg_next() % 6) : row.stall;
      exp_data = row.exp_last ? last_data0 : row.exp_data;
      run_txn(row.src, row.op, row.addr, wdata, stall, rdata, code);
      if (code !== row.exp_code) fail_value("resp_code", code, row.exp_code);
      if (rdata !== exp_data) fail_value("resp_data", rdata, exp_data);
      if (row.op == dmi_pkg::DMI_WRITE && row.addr == dbg_cfg_pkg::AddrData0) begin
        last_data0 = wdata;
      end
    end
    end_test(test_name(cur_test));

    // source isolation, DTM request parked while JTAG runs
    begin_test();
    if (cur_src != 1'b1) select_source(1'b1);
    cur_src = 1'b1;
    drive_req(0, 1'b1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrData0, 32'hdead_beef);
    iso_check = 1'b1;
    run_txn(1, dmi_pkg::DMI_READ, dbg_cfg_pkg::AddrData0, '0, 2, rdata, code);
    iso_check = 1'b0;
    drive_req(0, 1'b0, dmi_pkg::DMI_NOP, '0, '0);
    if (rdata !== last_data0) fail_value("jtag resp_data", rdata, last_data0);
    end_test("4 source isolation");

    // reset and halt mask outputs
    begin_test();
    run_txn(1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrDmcontrol, '1, 0, rdata, code);
    if (debug_req !== 2'b11) fail_value("debug_req_o", debug_req, 2'b11);
    if (ndmreset !== 1'b1) fail_value("ndmreset_o", ndmreset, 1);
    run_txn(1, dmi_pkg::DMI_READ, dbg_cfg_pkg::AddrDmcontrol, '0, 0, rdata, code);
    if (rdata !== ctrl_word(1, 1, 2'b11)) fail_value("dmcontrol", rdata, ctrl_word(1, 1, 2'b11));
    run_txn(1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrDmcontrol, ctrl_word(0, 1, 2'b11), 0,
            rdata, code);
    if (debug_req !== '0) fail_value("debug_req_o with active clear", debug_req, 0);
    if (ndmreset !== 1'b1) fail_value("ndmreset_o", ndmreset, 1);
    run_txn(1, dmi_pkg::DMI_WRITE, dbg_cfg_pkg::AddrDmcontrol, '0, 0, rdata, code);
    if (ndmreset !== 1'b0) fail_value("ndmreset_o", ndmreset, 0);
    end_test("6 reset and halt mask outputs");

    $display("tests: %0d, transactions: %0d, errors: %0d", n_tests, n_txns, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
verilog/dbg_cfg_pkg.sv
verilog/dmi_pkg.sv
verilog/dmi_source_mux.sv
verilog/dmi_req_fsm.sv
verilog/dm_regs.sv
verilog/debug_holdoff_timer.sv
verilog/debug_front_top.sv
verif/tb_clk_gen.sv
verif/debug_front_tb.sv

//--- Bender.yml
package:
  name: debug_front

sources:
  - files:
      - verilog/dbg_cfg_pkg.sv
      - verilog/dmi_pkg.sv
      - verilog/dmi_source_mux.sv
      - verilog/dmi_req_fsm.sv
      - verilog/dm_regs.sv
      - verilog/debug_holdoff_timer.sv
      - verilog/debug_front_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/debug_front_tb.sv
